/* include/iq_params.svh */
// issue queue sizing macros: queue depth, register counts, banks, dispatch width, read ports

`ifndef IQ_PARAMS_SVH
`define IQ_PARAMS_SVH

// queue entries
`define IQ_ENTRIES 8

// dispatch ways offered per cycle
`define DISPATCH_WAYS 4

// physical registers
`define PR_COUNT 64
`define LOG_PR_COUNT 6

// register file banks, bank is the low bits of the register number
`define PRF_BANK_COUNT 4
`define LOG_PRF_BANK_COUNT 2

// ROB index width
`define LOG_ROB_ENTRIES 7

// shared register file read ports
`define PRF_READ_PORTS 2

`endif

/* rtl/core_types_pkg.sv */
// operation enums, operation union, dispatch, writeback, issue and read request structs

`default_nettype none

`include "iq_params.svh"

package core_types_pkg;

	// ALU reg-reg ops, funct7 bit over funct3
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_sra  = 4'b1101
	} alu_op_t;

	// multiply-divide ops, funct3 order
	typedef enum logic [3:0] {
		mdu_mul    = 4'b0000,
		mdu_mulh   = 4'b0001,
		mdu_mulhsu = 4'b0010,
		mdu_mulhu  = 4'b0011,
		mdu_div    = 4'b0100,
		mdu_divu   = 4'b0101,
		mdu_rem    = 4'b0110,
		mdu_remu   = 4'b0111
	} mdu_op_t;

	// same op word, read per target pipeline
	typedef union packed {
		alu_op_t alu;
		mdu_op_t mdu;
	} op_u;

	typedef struct packed {
		logic                         attempt;
		logic                         valid_alu_reg;
		logic                         valid_mul_div;
		op_u                          op;
		logic [`LOG_PR_COUNT-1:0]     A_PR;
		logic                         A_ready;
		logic [`LOG_PR_COUNT-1:0]     B_PR;
		logic                         B_ready;
		logic [`LOG_PR_COUNT-1:0]     dest_PR;
		logic [`LOG_ROB_ENTRIES-1:0]  ROB_index;
	} dispatch_way_t;

	typedef struct packed {
		logic [`PRF_BANK_COUNT-1:0] valid;
		logic [`PRF_BANK_COUNT-1:0][`LOG_PR_COUNT-`LOG_PRF_BANK_COUNT-1:0] upper_PR;
	} wb_bus_t;

	typedef struct packed {
		logic                           valid;
		op_u                            op;
		logic                           A_forward;
		logic [`LOG_PRF_BANK_COUNT-1:0] A_bank;
		logic                           B_forward;
		logic [`LOG_PRF_BANK_COUNT-1:0] B_bank;
		logic [`LOG_PR_COUNT-1:0]       dest_PR;
		logic [`LOG_ROB_ENTRIES-1:0]    ROB_index;
	} issue_t;

	typedef struct packed {
		logic                     A_valid;
		logic [`LOG_PR_COUNT-1:0] A_PR;
		logic                     B_valid;
		logic [`LOG_PR_COUNT-1:0] B_PR;
	} prf_req_t;

	typedef enum logic {
		alu_reg = 1'b0,
		mul_div = 1'b1
	} pipe_e;

endpackage

`default_nettype wire

/* rtl/alu_reg_mdu_iq.sv */
// ALU reg-reg and multiply-divide issue queue with dispatch, wakeup, oldest-ready select and issue

`default_nettype none

`include "iq_params.svh"

module alu_reg_mdu_iq
	import core_types_pkg::*;
(
	input  logic                               CLK,
	input  logic                               nRST,

	input  dispatch_way_t [`DISPATCH_WAYS-1:0] dispatch,
	output logic [`DISPATCH_WAYS-1:0]          dispatch_ack,

	input  logic                               alu_reg_pipeline_ready,
	input  logic                               mul_div_pipeline_ready,

	input  wb_bus_t                            wb_bus,

	// read port arbitration indexed by pipe_e
	output logic [1:0]                         req,
	output logic [1:0][1:0]                    read_count,
	input  logic [1:0]                         grant,

	output issue_t                             issue_alu_reg,
	output issue_t                             issue_mul_div,
	output prf_req_t                           prf_req_alu_reg,
	output prf_req_t                           prf_req_mul_div
);

	localparam int ENTRY_IDX_W = $clog2(`IQ_ENTRIES);
	localparam int COUNT_W = $clog2(`IQ_ENTRIES + 1);

	typedef struct packed {
		logic                         to_alu_reg;
		logic                         to_mul_div;
		op_u                          op;
		logic [`LOG_PR_COUNT-1:0]     A_PR;
		logic                         A_ready;
		logic [`LOG_PR_COUNT-1:0]     B_PR;
		logic                         B_ready;
		logic [`LOG_PR_COUNT-1:0]     dest_PR;
		logic [`LOG_ROB_ENTRIES-1:0]  ROB_index;
	} iq_entry_t;

	// entries compact toward 0 so a lower index is older
	logic [`IQ_ENTRIES-1:0]          entry_valid;
	logic [`IQ_ENTRIES-1:0]          next_valid;
	iq_entry_t [`IQ_ENTRIES-1:0]     entries;
	iq_entry_t [`IQ_ENTRIES-1:0]     next_entries;

	logic [COUNT_W-1:0]              occupancy;
	logic [COUNT_W-1:0]              free_count;
	logic [COUNT_W-1:0]              ack_count;

	logic [`IQ_ENTRIES-1:0]          A_wake;
	logic [`IQ_ENTRIES-1:0]          B_wake;
	logic [1:0][`IQ_ENTRIES-1:0]     cand;
	logic [1:0]                      found;
	logic [1:0][ENTRY_IDX_W-1:0]     sel_idx;
	iq_entry_t [1:0]                 sel_entry;
	logic [1:0]                      pipe_ready;
	logic [1:0]                      A_forward;
	logic [1:0]                      B_forward;
	logic [1:0]                      issue_valid;
	logic [`IQ_ENTRIES-1:0]          issued_mask;
	issue_t [1:0]                    issue_by_pipe;
	prf_req_t [1:0]                  prf_req_by_pipe;
	logic [ENTRY_IDX_W-1:0]          wr_ptr;

	// register named by its bank's writeback slot
	function automatic logic woken(input logic [`LOG_PR_COUNT-1:0] pr, input wb_bus_t wb);
		logic [`LOG_PRF_BANK_COUNT-1:0] bank;
		bank = pr[`LOG_PRF_BANK_COUNT-1:0];
		return wb.valid[bank] &&
			(wb.upper_PR[bank] == pr[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT]);
	endfunction

	assign pipe_ready[alu_reg] = alu_reg_pipeline_ready;
	assign pipe_ready[mul_div] = mul_div_pipeline_ready;

	// ------------------------------------------------------------------
	// dispatch acceptance

	// free count from the start of the cycle without this cycle's issue
	always_comb begin
		occupancy = '0;
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			occupancy = occupancy + COUNT_W'(entry_valid[i]);
		end
		free_count = COUNT_W'(`IQ_ENTRIES) - occupancy;
		ack_count = '0;
		for (int w = 0; w < `DISPATCH_WAYS; w++) begin
			dispatch_ack[w] = dispatch[w].attempt && (ack_count < free_count);
			if (dispatch_ack[w]) begin
				ack_count = ack_count + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// wakeup and oldest-ready select

	always_comb begin
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			A_wake[i] = woken(entries[i].A_PR, wb_bus);
			B_wake[i] = woken(entries[i].B_PR, wb_bus);
			cand[alu_reg][i] = entry_valid[i] && entries[i].to_alu_reg &&
				(entries[i].A_ready || A_wake[i]) && (entries[i].B_ready || B_wake[i]);
			cand[mul_div][i] = entry_valid[i] && entries[i].to_mul_div &&
				(entries[i].A_ready || A_wake[i]) && (entries[i].B_ready || B_wake[i]);
		end
	end

	// scan down so the lowest ready index wins
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			found[p] = 1'b0;
			sel_idx[p] = '0;
			for (int i = `IQ_ENTRIES - 1; i >= 0; i--) begin
				if (cand[p][i]) begin
					found[p] = 1'b1;
					sel_idx[p] = ENTRY_IDX_W'(i);
				end
			end
		end
	end

	// forwarded operands need no read port
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			sel_entry[p] = entries[sel_idx[p]];
			A_forward[p] = A_wake[sel_idx[p]] && !sel_entry[p].A_ready;
			B_forward[p] = B_wake[sel_idx[p]] && !sel_entry[p].B_ready;
			req[p] = found[p] && pipe_ready[p];
			read_count[p] = {1'b0, !A_forward[p]} + {1'b0, !B_forward[p]};
		end
	end

	// ------------------------------------------------------------------
	// issue packing

	always_comb begin
		issued_mask = '0;
		for (int p = 0; p < 2; p++) begin
			issue_valid[p] = req[p] && grant[p];
			issue_by_pipe[p] = '0;
			prf_req_by_pipe[p] = '0;
			if (issue_valid[p]) begin
				issued_mask[sel_idx[p]] = 1'b1;
				issue_by_pipe[p].op = sel_entry[p].op;
				issue_by_pipe[p].valid = 1'b1;
				issue_by_pipe[p].A_forward = A_forward[p];
				issue_by_pipe[p].A_bank = sel_entry[p].A_PR[`LOG_PRF_BANK_COUNT-1:0];
				issue_by_pipe[p].B_forward = B_forward[p];
				issue_by_pipe[p].B_bank = sel_entry[p].B_PR[`LOG_PRF_BANK_COUNT-1:0];
				issue_by_pipe[p].dest_PR = sel_entry[p].dest_PR;
				issue_by_pipe[p].ROB_index = sel_entry[p].ROB_index;
				prf_req_by_pipe[p].A_valid = !A_forward[p];
				prf_req_by_pipe[p].A_PR = sel_entry[p].A_PR;
				prf_req_by_pipe[p].B_valid = !B_forward[p];
				prf_req_by_pipe[p].B_PR = sel_entry[p].B_PR;
			end
		end
	end

	assign issue_alu_reg = issue_by_pipe[alu_reg];
	assign issue_mul_div = issue_by_pipe[mul_div];
	assign prf_req_alu_reg = prf_req_by_pipe[alu_reg];
	assign prf_req_mul_div = prf_req_by_pipe[mul_div];

	// ------------------------------------------------------------------
	// compaction and append

	always_comb begin
		next_valid = '0;
		next_entries = entries;
		wr_ptr = '0;
		// survivors keep age order and absorb this cycle's wakeups
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			if (entry_valid[i] && !issued_mask[i]) begin
				next_valid[wr_ptr] = 1'b1;
				next_entries[wr_ptr] = entries[i];
				next_entries[wr_ptr].A_ready = entries[i].A_ready || A_wake[i];
				next_entries[wr_ptr].B_ready = entries[i].B_ready || B_wake[i];
				wr_ptr = wr_ptr + 1'b1;
			end
		end
		// new ops behind them in way order
		for (int w = 0; w < `DISPATCH_WAYS; w++) begin
			if (dispatch_ack[w]) begin
				next_valid[wr_ptr] = 1'b1;
				next_entries[wr_ptr].to_alu_reg = dispatch[w].valid_alu_reg;
				next_entries[wr_ptr].to_mul_div = dispatch[w].valid_mul_div;
				next_entries[wr_ptr].op = dispatch[w].op;
				next_entries[wr_ptr].A_PR = dispatch[w].A_PR;
				next_entries[wr_ptr].A_ready = dispatch[w].A_ready ||
					woken(dispatch[w].A_PR, wb_bus);
				next_entries[wr_ptr].B_PR = dispatch[w].B_PR;
				next_entries[wr_ptr].B_ready = dispatch[w].B_ready ||
					woken(dispatch[w].B_PR, wb_bus);
				next_entries[wr_ptr].dest_PR = dispatch[w].dest_PR;
				next_entries[wr_ptr].ROB_index = dispatch[w].ROB_index;
				wr_ptr = wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			entry_valid <= '0;
		end
		else begin
			entry_valid <= next_valid;
		end
	end

	always_ff @(posedge CLK) begin
		entries <= next_entries;
	end

endmodule

`default_nettype wire

/* rtl/prf_read_arbiter.sv */
// register file read port arbiter between the two issue selectors, rotating priority

`default_nettype none

`include "iq_params.svh"

module prf_read_arbiter
	import core_types_pkg::*;
(
	input  logic            CLK,
	input  logic            nRST,

	// indexed by pipe_e
	input  logic [1:0]      req,
	input  logic [1:0][1:0] read_count,
	output logic [1:0]      grant
);

	logic [2:0] read_sum;
	logic       conflict;
	pipe_e      priority_pipe;

	// ------------------------------------------------------------------
	// port pool check

	always_comb begin
		read_sum = '0;
		for (int p = 0; p < 2; p++) begin
			if (req[p]) begin
				read_sum = read_sum + {1'b0, read_count[p]};
			end
		end
		// a lone requester always fits
		conflict = req[alu_reg] && req[mul_div] && (read_sum > 3'(`PRF_READ_PORTS));
	end

	always_comb begin
		if (conflict) begin
			grant = '0;
			grant[priority_pipe] = 1'b1;
		end
		else begin
			grant = req;
		end
	end

	// ------------------------------------------------------------------
	// priority rotation

	// hand priority over after each conflict so neither side starves
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			priority_pipe <= alu_reg;
		end
		else if (conflict) begin
			priority_pipe <= (priority_pipe == alu_reg) ? mul_div : alu_reg;
		end
	end

endmodule

`default_nettype wire

/* rtl/alu_reg_mdu_iq_wrapper.sv */
// registered top level around the issue queue and the read port arbiter

`default_nettype none

`include "iq_params.svh"

module alu_reg_mdu_iq_wrapper
	import core_types_pkg::*;
(
	input  logic                               CLK,
	input  logic                               nRST,

	input  dispatch_way_t [`DISPATCH_WAYS-1:0] next_dispatch,
	output logic [`DISPATCH_WAYS-1:0]          last_dispatch_ack,

	input  logic                               next_alu_reg_pipeline_ready,
	input  logic                               next_mul_div_pipeline_ready,

	input  wb_bus_t                            next_wb_bus,

	output issue_t                             last_issue_alu_reg,
	output issue_t                             last_issue_mul_div,
	output prf_req_t                           last_prf_req_alu_reg,
	output prf_req_t                           last_prf_req_mul_div
);

	// flopped inputs
	dispatch_way_t [`DISPATCH_WAYS-1:0] dispatch;
	logic                               alu_reg_pipeline_ready;
	logic                               mul_div_pipeline_ready;
	wb_bus_t                            wb_bus;

	// queue outputs before the output stage
	logic [`DISPATCH_WAYS-1:0]          dispatch_ack;
	issue_t                             issue_alu_reg;
	issue_t                             issue_mul_div;
	prf_req_t                           prf_req_alu_reg;
	prf_req_t                           prf_req_mul_div;

	// queue to arbiter
	logic [1:0]                         req;
	logic [1:0][1:0]                    read_count;
	logic [1:0]                         grant;

	// ------------------------------------------------------------------
	// core

	alu_reg_mdu_iq iq (
		.CLK                    (CLK),
		.nRST                   (nRST),
		.dispatch               (dispatch),
		.dispatch_ack           (dispatch_ack),
		.alu_reg_pipeline_ready (alu_reg_pipeline_ready),
		.mul_div_pipeline_ready (mul_div_pipeline_ready),
		.wb_bus                 (wb_bus),
		.req                    (req),
		.read_count             (read_count),
		.grant                  (grant),
		.issue_alu_reg          (issue_alu_reg),
		.issue_mul_div          (issue_mul_div),
		.prf_req_alu_reg        (prf_req_alu_reg),
		.prf_req_mul_div        (prf_req_mul_div)
	);

	prf_read_arbiter arbiter (
		.CLK        (CLK),
		.nRST       (nRST),
		.req        (req),
		.read_count (read_count),
		.grant      (grant)
	);

	// ------------------------------------------------------------------
	// boundary registers

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			dispatch <= '0;
			alu_reg_pipeline_ready <= 1'b0;
			mul_div_pipeline_ready <= 1'b0;
			wb_bus <= '0;
			last_dispatch_ack <= '0;
			last_issue_alu_reg <= '0;
			last_issue_mul_div <= '0;
			last_prf_req_alu_reg <= '0;
			last_prf_req_mul_div <= '0;
		end
		else begin
			// input side
			dispatch <= next_dispatch;
			alu_reg_pipeline_ready <= next_alu_reg_pipeline_ready;
			mul_div_pipeline_ready <= next_mul_div_pipeline_ready;
			wb_bus <= next_wb_bus;
			// output side
			last_dispatch_ack <= dispatch_ack;
			last_issue_alu_reg <= issue_alu_reg;
			last_issue_mul_div <= issue_mul_div;
			last_prf_req_alu_reg <= prf_req_alu_reg;
			last_prf_req_mul_div <= prf_req_mul_div;
		end
	end

endmodule

`default_nettype wire

/* verification/alu_reg_mdu_iq_tb.sv */
// directed testbench for the issue queue wrapper with clock, reset, watchdog, model, checks and tests

`default_nettype none

`include "iq_params.svh"

module alu_reg_mdu_iq_tb
	import core_types_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int TEST_COUNT = 6;
	localparam int CYCLES_PER_TEST = 40;
	localparam int TEST_CYCLES = RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST;
	localparam int WATCHDOG_TIME = TEST_CYCLES * 10 * 2;
	localparam int WAIT_LIMIT = 30;

	logic                               CLK;
	logic                               nRST;
	dispatch_way_t [`DISPATCH_WAYS-1:0] next_dispatch;
	logic                               next_alu_reg_pipeline_ready;
	logic                               next_mul_div_pipeline_ready;
	wb_bus_t                            next_wb_bus;
	logic [`DISPATCH_WAYS-1:0]          last_dispatch_ack;
	issue_t                             last_issue_alu_reg;
	issue_t                             last_issue_mul_div;
	prf_req_t                           last_prf_req_alu_reg;
	prf_req_t                           last_prf_req_mul_div;

	// model input stage and entry list with the oldest first
	dispatch_way_t [`DISPATCH_WAYS-1:0] held_dispatch;
	logic                               held_alu_ready;
	logic                               held_mdu_ready;
	wb_bus_t                            held_wb;
	dispatch_way_t                      model_q [$];
	pipe_e                              model_prio;
	logic [`DISPATCH_WAYS-1:0]          exp_ack;
	issue_t [1:0]                       exp_issue;
	prf_req_t [1:0]                     exp_prf;

	int                                 issued [2];
	int                                 parked [2];
	int                                 forwarded;
	pipe_e                              order_log [$];
	logic [16:0]                        lfsr_state;

	alu_reg_mdu_iq_wrapper uut (
		.CLK                         (CLK),
		.nRST                        (nRST),
		.next_dispatch               (next_dispatch),
		.last_dispatch_ack           (last_dispatch_ack),
		.next_alu_reg_pipeline_ready (next_alu_reg_pipeline_ready),
		.next_mul_div_pipeline_ready (next_mul_div_pipeline_ready),
		.next_wb_bus                 (next_wb_bus),
		.last_issue_alu_reg          (last_issue_alu_reg),
		.last_issue_mul_div          (last_issue_mul_div),
		.last_prf_req_alu_reg        (last_prf_req_alu_reg),
		.last_prf_req_mul_div        (last_prf_req_mul_div)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		#(WATCHDOG_TIME);
		stop_on_error("timeout: the tests did not finish in the allowed time");
	end

	// ----------------------------------------------------------------------
	// helpers

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// x^17 + x^14 + 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[16] ^ lfsr_state[13];
			lfsr_state = {lfsr_state[15:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [`LOG_PR_COUNT-1:0] rand_pr();
		logic [31:0] bits;
		bits = rand_bits(`LOG_PR_COUNT);
		return bits[`LOG_PR_COUNT-1:0];
	endfunction

	function automatic pipe_e rand_pipe();
		logic [31:0] bits;
		bits = rand_bits(1);
		return pipe_e'(bits[0]);
	endfunction

	// B source always ready and A as given
	function automatic dispatch_way_t make_op(input pipe_e pipe, input logic a_ready,
		input logic [`LOG_PR_COUNT-1:0] a_pr);
		dispatch_way_t w;
		logic [31:0]   bits;
		w = '0;
		w.attempt = 1'b1;
		w.valid_alu_reg = (pipe == alu_reg);
		w.valid_mul_div = (pipe == mul_div);
		bits = rand_bits(3);
		if (pipe == alu_reg) begin
			w.op.alu = alu_op_t'({1'b0, bits[2:0]});
		end
		else begin
			w.op.mdu = mdu_op_t'({1'b0, bits[2:0]});
		end
		w.A_PR = a_pr;
		w.A_ready = a_ready;
		w.B_PR = rand_pr();
		w.B_ready = 1'b1;
		w.dest_PR = rand_pr();
		bits = rand_bits(`LOG_ROB_ENTRIES);
		w.ROB_index = bits[`LOG_ROB_ENTRIES-1:0];
		return w;
	endfunction

	// bank is the low bits and the bus slot holds the rest
	function automatic logic woken_by(input logic [`LOG_PR_COUNT-1:0] pr, input wb_bus_t wb);
		logic [`LOG_PRF_BANK_COUNT-1:0] bank;
		bank = pr[`LOG_PRF_BANK_COUNT-1:0];
		return wb.valid[bank] && (wb.upper_PR[bank] == pr[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT]);
	endfunction

	// ----------------------------------------------------------------------
	// reference model for one internal cycle

	function automatic void model_cycle();
		int            free_slots;
		int            taken;
		int            reads;
		int            sel [2];
		logic [1:0]    req;
		logic [1:0]    grant;
		logic [1:0]    fwd_a;
		logic [1:0]    fwd_b;
		logic [1:0]    pipe_ready;
		dispatch_way_t e;
		pipe_ready = {held_mdu_ready, held_alu_ready};
		// acceptance against the free count at the start of the cycle
		free_slots = `IQ_ENTRIES - model_q.size();
		taken = 0;
		exp_ack = '0;
		for (int w = 0; w < `DISPATCH_WAYS; w++) begin
			if (held_dispatch[w].attempt && taken < free_slots) begin
				exp_ack[w] = 1'b1;
				taken++;
			end
		end
		reads = 0;
		for (int p = 0; p < 2; p++) begin
			sel[p] = -1;
			fwd_a[p] = 1'b0;
			fwd_b[p] = 1'b0;
			for (int i = 0; i < model_q.size(); i++) begin
				e = model_q[i];
				if (sel[p] < 0 && ((p == int'(alu_reg)) ? e.valid_alu_reg : e.valid_mul_div) &&
					(e.A_ready || woken_by(e.A_PR, held_wb)) &&
					(e.B_ready || woken_by(e.B_PR, held_wb))) begin
					sel[p] = i;
				end
			end
			if (sel[p] >= 0) begin
				e = model_q[sel[p]];
				fwd_a[p] = !e.A_ready && woken_by(e.A_PR, held_wb);
				fwd_b[p] = !e.B_ready && woken_by(e.B_PR, held_wb);
			end
			req[p] = (sel[p] >= 0) && pipe_ready[p];
			if (req[p]) begin
				reads += (fwd_a[p] ? 0 : 1) + (fwd_b[p] ? 0 : 1);
			end
		end
		// over the pool only the priority holder issues and priority moves on
		if (req == 2'b11 && reads > `PRF_READ_PORTS) begin
			grant = '0;
			grant[model_prio] = 1'b1;
			model_prio = (model_prio == alu_reg) ? mul_div : alu_reg;
		end
		else begin
			grant = req;
		end
		exp_issue = '0;
		exp_prf = '0;
		for (int p = 0; p < 2; p++) begin
			if (grant[p]) begin
				e = model_q[sel[p]];
				exp_issue[p].valid = 1'b1;
				exp_issue[p].op = e.op;
				exp_issue[p].A_forward = fwd_a[p];
				exp_issue[p].A_bank = e.A_PR[`LOG_PRF_BANK_COUNT-1:0];
				exp_issue[p].B_forward = fwd_b[p];
				exp_issue[p].B_bank = e.B_PR[`LOG_PRF_BANK_COUNT-1:0];
				exp_issue[p].dest_PR = e.dest_PR;
				exp_issue[p].ROB_index = e.ROB_index;
				exp_prf[p].A_valid = !fwd_a[p];
				exp_prf[p].A_PR = e.A_PR;
				exp_prf[p].B_valid = !fwd_b[p];
				exp_prf[p].B_PR = e.B_PR;
			end
		end
		for (int i = 0; i < model_q.size(); i++) begin
			e = model_q[i];
			e.A_ready = e.A_ready || woken_by(e.A_PR, held_wb);
			e.B_ready = e.B_ready || woken_by(e.B_PR, held_wb);
			model_q[i] = e;
		end
		for (int i = model_q.size() - 1; i >= 0; i--) begin
			if ((grant[0] && sel[0] == i) || (grant[1] && sel[1] == i)) begin
				model_q.delete(i);
			end
		end
		for (int w = 0; w < `DISPATCH_WAYS; w++) begin
			if (exp_ack[w]) begin
				e = held_dispatch[w];
				e.A_ready = e.A_ready || woken_by(e.A_PR, held_wb);
				e.B_ready = e.B_ready || woken_by(e.B_PR, held_wb);
				model_q.push_back(e);
			end
		end
	endfunction

	// ----------------------------------------------------------------------
	// compare tasks and the cycle step

	task automatic check_ack(input string name, input logic [`DISPATCH_WAYS-1:0] got,
		input logic [`DISPATCH_WAYS-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("error: %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_issue(input string name, input issue_t got, input issue_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("error: %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_prf_req(input string name, input prf_req_t got, input prf_req_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("error: %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic log_issue(input pipe_e pipe, input issue_t iss);
		if (iss.valid) begin
			issued[pipe]++;
			order_log.push_back(pipe);
			if (iss.A_forward || iss.B_forward) begin
				forwarded++;
			end
		end
	endtask

	// model and input stage move on the edge and outputs are checked just after
	task automatic step();
		@(posedge CLK);
		model_cycle();
		held_dispatch = next_dispatch;
		held_alu_ready = next_alu_reg_pipeline_ready;
		held_mdu_ready = next_mul_div_pipeline_ready;
		held_wb = next_wb_bus;
		#1;
		check_ack("last_dispatch_ack", last_dispatch_ack, exp_ack);
		check_issue("last_issue_alu_reg", last_issue_alu_reg, exp_issue[alu_reg]);
		check_issue("last_issue_mul_div", last_issue_mul_div, exp_issue[mul_div]);
		check_prf_req("last_prf_req_alu_reg", last_prf_req_alu_reg, exp_prf[alu_reg]);
		check_prf_req("last_prf_req_mul_div", last_prf_req_mul_div, exp_prf[mul_div]);
		log_issue(alu_reg, last_issue_alu_reg);
		log_issue(mul_div, last_issue_mul_div);
	endtask

	task automatic clear_counts();
		issued[0] = 0;
		issued[1] = 0;
		forwarded = 0;
		order_log.delete();
	endtask

	task automatic wait_issued(input pipe_e pipe, input int count, input string what);
		int cycles;
		cycles = 0;
		while (issued[pipe] < count && cycles < WAIT_LIMIT) begin
			step();
			cycles++;
		end
		if (issued[pipe] < count) begin
			stop_on_error($sformatf("%s: only %0d of %0d ops issued in time",
				what, issued[pipe], count));
		end
	endtask

	// ----------------------------------------------------------------------
	// tests

	task automatic test_reset();
		step();
		check_ack("last_dispatch_ack", last_dispatch_ack, '0);
		check_issue("last_issue_alu_reg", last_issue_alu_reg, '0);
		check_issue("last_issue_mul_div", last_issue_mul_div, '0);
		check_prf_req("last_prf_req_alu_reg", last_prf_req_alu_reg, '0);
		check_prf_req("last_prf_req_mul_div", last_prf_req_mul_div, '0);
	endtask

	// ten ops into an empty queue with both pipelines held off
	task automatic test_capacity();
		pipe_e pipe;
		clear_counts();
		parked[0] = 0;
		parked[1] = 0;
		next_alu_reg_pipeline_ready = 1'b0;
		next_mul_div_pipeline_ready = 1'b0;
		for (int g = 0; g < 3; g++) begin
			next_dispatch = '0;
			for (int w = 0; w < `DISPATCH_WAYS; w++) begin
				if (g < 2 || w < 2) begin
					pipe = rand_pipe();
					next_dispatch[w] = make_op(pipe, 1'b1, rand_pr());
					// only the first eight find a free entry
					if (g < 2) begin
						parked[pipe]++;
					end
				end
			end
			step();
			if (g > 0) begin
				check_ack("last_dispatch_ack", last_dispatch_ack, 4'b1111);
			end
		end
		next_dispatch = '0;
		step();
		check_ack("last_dispatch_ack", last_dispatch_ack, 4'b0000);
	endtask

	task automatic test_oldest_first();
		clear_counts();
		next_alu_reg_pipeline_ready = 1'b1;
		wait_issued(alu_reg, parked[alu_reg], "oldest-first alu_reg");
		if (issued[mul_div] != 0) begin
			stop_on_error("multiply-divide op issued while its pipeline was not ready");
		end
		next_mul_div_pipeline_ready = 1'b1;
		wait_issued(mul_div, parked[mul_div], "oldest-first mul_div");
	endtask

	task automatic test_wakeup();
		logic [`LOG_PR_COUNT-1:0]       wait_pr;
		logic [`LOG_PRF_BANK_COUNT-1:0] bank;
		clear_counts();
		wait_pr = rand_pr();
		next_dispatch[0] = make_op(alu_reg, 1'b0, wait_pr);
		next_dispatch[1] = make_op(mul_div, 1'b0, wait_pr);
		next_dispatch[2] = make_op(alu_reg, 1'b0, wait_pr);
		next_dispatch[3] = make_op(alu_reg, 1'b0, wait_pr);
		step();
		next_dispatch = '0;
		step();
		// writeback slot of the waited register's bank
		bank = wait_pr[`LOG_PRF_BANK_COUNT-1:0];
		next_wb_bus = '0;
		next_wb_bus.valid[bank] = 1'b1;
		next_wb_bus.upper_PR[bank] = wait_pr[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT];
		step();
		next_wb_bus = '0;
		wait_issued(alu_reg, 3, "wakeup alu_reg");
		wait_issued(mul_div, 1, "wakeup mul_div");
		if (forwarded != 2) begin
			stop_on_error($sformatf("wakeup: %0d ops issued with forwarding, 2 expected",
				forwarded));
		end
	endtask

	// three two-read ops per pipeline released together
	task automatic test_conflict();
		pipe_e expect_pipe;
		clear_counts();
		next_alu_reg_pipeline_ready = 1'b0;
		next_mul_div_pipeline_ready = 1'b0;
		for (int w = 0; w < `DISPATCH_WAYS; w++) begin
			next_dispatch[w] = make_op((w % 2 == 0) ? alu_reg : mul_div, 1'b1, rand_pr());
		end
		step();
		next_dispatch = '0;
		next_dispatch[0] = make_op(alu_reg, 1'b1, rand_pr());
		next_dispatch[1] = make_op(mul_div, 1'b1, rand_pr());
		step();
		next_dispatch = '0;
		step();
		order_log.delete();
		next_alu_reg_pipeline_ready = 1'b1;
		next_mul_div_pipeline_ready = 1'b1;
		wait_issued(alu_reg, 3, "conflict alu_reg");
		wait_issued(mul_div, 3, "conflict mul_div");
		for (int k = 0; k < 6; k++) begin
			expect_pipe = (k % 2 == 0) ? alu_reg : mul_div;
			if (k >= order_log.size() || order_log[k] != expect_pipe) begin
				stop_on_error("read-port conflict: pipelines did not alternate from alu_reg");
			end
		end
	endtask

	task automatic test_backpressure();
		clear_counts();
		next_alu_reg_pipeline_ready = 1'b0;
		next_mul_div_pipeline_ready = 1'b1;
		for (int g = 0; g < 2; g++) begin
			for (int w = 0; w < `DISPATCH_WAYS; w++) begin
				next_dispatch[w] = make_op((w % 2 == 0) ? alu_reg : mul_div, 1'b1, rand_pr());
			end
			step();
		end
		next_dispatch = '0;
		wait_issued(mul_div, 4, "back-pressure mul_div");
		if (issued[alu_reg] != 0) begin
			stop_on_error("back-pressure: ALU op issued while its pipeline was not ready");
		end
		next_alu_reg_pipeline_ready = 1'b1;
		wait_issued(alu_reg, 4, "back-pressure alu_reg");
	endtask

	// ----------------------------------------------------------------------
	// main sequence

	initial begin
		lfsr_state = 17'd92787;
		nRST = 1'b0;
		next_dispatch = '0;
		next_alu_reg_pipeline_ready = 1'b0;
		next_mul_div_pipeline_ready = 1'b0;
		next_wb_bus = '0;
		held_dispatch = '0;
		held_alu_ready = 1'b0;
		held_mdu_ready = 1'b0;
		held_wb = '0;
		model_prio = alu_reg;
		model_q.delete();
		clear_counts();
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		nRST = 1'b1;
		test_reset();
		test_capacity();
		test_oldest_first();
		test_wakeup();
		test_conflict();
		test_backpressure();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
rtl/core_types_pkg.sv
rtl/alu_reg_mdu_iq.sv
rtl/prf_read_arbiter.sv
rtl/alu_reg_mdu_iq_wrapper.sv
verification/alu_reg_mdu_iq_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= alu_reg_mdu_iq_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
